// File: list.f
ppu_pkg.sv
ppu_raster_counter.sv
ppu_background.sv
ppu_bus_arbiter.sv
ppu_blender.sv
ppu_run_ctrl.sv
ppu_top.sv
tb_ppu_assertions.sv
tb_ppu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ppu \
	--Mdir obj_dir -o sim_ppu
./obj_dir/sim_ppu 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

// File: tb_ppu.sv
/*
 * PPU testbench
 * Random memory contents and waits, a pixel model of the blended
 * layers, and raster-order checks of the output stream
 */
module tb_ppu;
	timeunit 1ns;
	timeprecision 100ps;
	import ppu_pkg::*;

	// Pixels per test plus settle and reset overhead
	localparam int TEST_LEN_SUM = 32 + 32 + 32 + 96 + 120 + 32 + 50 + 6 * 12;
	localparam int CYCLE_LIMIT  = 4 * TEST_LEN_SUM * 6;

	logic              clk_ppu = 1'b0;
	logic              rst_n_ppu;
	ppu_cfg_t          cfg;
	bg_cfg_t [1:0]     bg_cfg;
	logic              run_i;
	logic              halt_i;
	logic              running_o;
	logic              mem_req_o;
	addr_t             mem_addr_o;
	logic              mem_ack_i   = 1'b0;
	pixel_t            mem_rdata_i = '0;
	logic              pix_vld_o;
	colour_t           pix_o;
	logic              pix_rdy_i;

	integer            seed = 32'hb4e2d9df;
	integer            wait_seed;
	pixel_t            mem [4096];
	logic              pending = 1'b0;
	int                wait_cnt = 0;
	int                cycle_cnt = 0;
	int                test_num = 0;
	int                test_errs = 0;
	int                err_total = 0;
	int                fail_tests = 0;
	int                bus_errs_seen = 0;

	ppu_top #(
		.N_BG (2)
	) i_dut (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.cfg_i       (cfg),
		.bg_cfg_i    (bg_cfg),
		.run_i       (run_i),
		.halt_i      (halt_i),
		.running_o   (running_o),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i),
		.pix_vld_o   (pix_vld_o),
		.pix_o       (pix_o),
		.pix_rdy_i   (pix_rdy_i)
	);

	always #5 clk_ppu = ~clk_ppu;

	always @(posedge clk_ppu) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped delivering pixels", cycle_cnt);
			$display("Some tests failed");
			$finish;
		end
	end

	// ----------------------------------------
	// Memory model with a 1 to 4 cycle ack wait

	always @(posedge clk_ppu) begin
		#1;
		mem_ack_i = 1'b0;
		if (!rst_n_ppu) begin
			pending = 1'b0;
		end else if (pending) begin
			wait_cnt--;
			if (wait_cnt == 0) begin
				mem_ack_i   = 1'b1;
				mem_rdata_i = mem[mem_addr_o[12:1]];
				pending     = 1'b0;
			end
		end else if (mem_req_o) begin
			pending  = 1'b1;
			wait_cnt = 1 + int'($random(wait_seed) & 32'h3);
		end
	end

	// ----------------------------------------
	// Pixel model

	// One layer drawn over the colour beneath it
	function automatic colour_t layer_over(input bg_cfg_t b, input int x, input int y,
			input colour_t below);
		int     px;
		int     py;
		addr_t  a;
		pixel_t w;
		if (!b.enable) begin
			return below;
		end
		px = (x + int'(b.scroll_x)) & ((1 << b.log_w) - 1);
		py = (y + int'(b.scroll_y)) & ((1 << b.log_h) - 1);
		a  = b.base + addr_t'(((py << b.log_w) + px) * 2);
		w  = mem[a[12:1]];
		return w[15] ? w[14:0] : below;
	endfunction

	function automatic colour_t expected_colour(input int x, input int y);
		colour_t c;
		c = cfg.default_colour;
		c = layer_over(bg_cfg[0], x, y, c);
		c = layer_over(bg_cfg[1], x, y, c);
		return c;
	endfunction

	// ----------------------------------------
	// Checks and test sequencing

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic set_display(input coord_t w, input coord_t h, input colour_t dc,
			input logic hv);
		cfg.disp_w         = w;
		cfg.disp_h         = h;
		cfg.default_colour = dc;
		cfg.halt_vsync     = hv;
	endtask

	task automatic configure_layer(input logic idx, input logic en, input pf_coord_t sx,
			input pf_coord_t sy, input log_size_t lw, input log_size_t lh, input addr_t base);
		bg_cfg[idx].enable   = en;
		bg_cfg[idx].scroll_x = sx;
		bg_cfg[idx].scroll_y = sy;
		bg_cfg[idx].log_w    = lw;
		bg_cfg[idx].log_h    = lh;
		bg_cfg[idx].base     = base;
	endtask

	task automatic assert_reset();
		@(posedge clk_ppu);
		#1;
		rst_n_ppu = 1'b0;
		run_i     = 1'b0;
		halt_i    = 1'b0;
		pix_rdy_i = 1'b0;
	endtask

	// Layers prefetch as soon as reset lifts, before run
	task automatic release_and_run();
		repeat (8) @(posedge clk_ppu);
		#1;
		rst_n_ppu = 1'b1;
		check_flag("running_o", running_o, 1'b0);
		check_flag("pix_vld_o", pix_vld_o, 1'b0);
		@(posedge clk_ppu);
		#1;
		run_i = 1'b1;
		@(posedge clk_ppu);
		#1;
		run_i = 1'b0;
		check_flag("running_o", running_o, 1'b1);
	endtask

	// Sampled mid-cycle before the transfer at the next edge
	task automatic stream_frames(input int n_frames, input bit rand_rdy);
		int x;
		int y;
		int got;
		int total;
		x     = 0;
		y     = 0;
		got   = 0;
		total = n_frames * (int'(cfg.disp_w) + 1) * (int'(cfg.disp_h) + 1);
		while (got < total) begin
			@(posedge clk_ppu);
			#1;
			pix_rdy_i = rand_rdy ? (($random(seed) & 32'h3) != 32'h0) : 1'b1;
			@(negedge clk_ppu);
			if (pix_vld_o && pix_rdy_i) begin
				check_colour($sformatf("pix_o at (%0d,%0d)", x, y), pix_o, expected_colour(x, y));
				got++;
				if (x == int'(cfg.disp_w)) begin
					x = 0;
					y = (y == int'(cfg.disp_h)) ? 0 : y + 1;
				end else begin
					x++;
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		int new_bus_errs;
		new_bus_errs   = i_dut.u_arb.i_arb_checks.fail_cnt - bus_errs_seen;
		bus_errs_seen += new_bus_errs;
		test_errs     += new_bus_errs;
		test_num++;
		if (test_errs == 0) begin
			$display("Test %0d, %s: ok", test_num, name);
		end else begin
			$display("Test %0d, %s: FAILED with %0d errors", test_num, name, test_errs);
			fail_tests++;
		end
		err_total += test_errs;
		test_errs = 0;
	endtask

	// ----------------------------------------
	// Test sequence

	initial begin
		rst_n_ppu = 1'b0;
		cfg       = '0;
		bg_cfg    = '0;
		run_i     = 1'b0;
		halt_i    = 1'b0;
		pix_rdy_i = 1'b0;
		for (int i = 0; i < 4096; i++) begin
			mem[i[11:0]] = pixel_t'($random(seed));
		end
		wait_seed = $random(seed);

		assert_reset();
		set_display(9'd7, 9'd3, 15'h1234, 1'b0);
		configure_layer(1'b0, 1'b1, 10'd0, 10'd0, 4'd3, 4'd2, 32'h100);
		configure_layer(1'b1, 1'b0, 10'd0, 10'd0, 4'd3, 4'd2, 32'h200);
		release_and_run();
		stream_frames(1, 1'b0);
		finish_test("single layer");

		assert_reset();
		configure_layer(1'b0, 1'b1, 10'd0, 10'd0, 4'd3, 4'd2, 32'h000);
		configure_layer(1'b1, 1'b1, 10'd0, 10'd0, 4'd3, 4'd2, 32'h800);
		release_and_run();
		stream_frames(1, 1'b0);
		finish_test("layer priority");

		assert_reset();
		set_display(9'd7, 9'd3, 15'h2a5c, 1'b0);
		configure_layer(1'b0, 1'b0, 10'd0, 10'd0, 4'd3, 4'd2, 32'h000);
		configure_layer(1'b1, 1'b0, 10'd0, 10'd0, 4'd3, 4'd2, 32'h800);
		release_and_run();
		stream_frames(1, 1'b0);
		finish_test("layers disabled");

		// 8 wide playfield under a 16 wide display
		assert_reset();
		set_display(9'd15, 9'd5, 15'h0f0f, 1'b0);
		configure_layer(1'b0, 1'b1, pf_coord_t'($random(seed)), pf_coord_t'($random(seed)),
			4'd3, 4'd3, 32'h400);
		configure_layer(1'b1, 1'b1, pf_coord_t'($random(seed)), pf_coord_t'($random(seed)),
			4'd4, 4'd3, 32'h600);
		release_and_run();
		stream_frames(1, 1'b0);
		finish_test("scroll wrap");

		assert_reset();
		set_display(9'd11, 9'd4, 15'h7c00, 1'b0);
		configure_layer(1'b0, 1'b1, pf_coord_t'($random(seed)), pf_coord_t'($random(seed)),
			4'd4, 4'd3, 32'h1000);
		configure_layer(1'b1, 1'b1, pf_coord_t'($random(seed)), pf_coord_t'($random(seed)),
			4'd3, 4'd4, 32'h1400);
		release_and_run();
		stream_frames(2, 1'b1);
		@(posedge clk_ppu);
		#1;
		pix_rdy_i = 1'b0;
		halt_i    = 1'b1;
		@(posedge clk_ppu);
		#1;
		halt_i = 1'b0;
		check_flag("running_o", running_o, 1'b0);
		finish_test("back-pressure, two frames");

		assert_reset();
		set_display(9'd7, 9'd3, 15'h03e0, 1'b1);
		configure_layer(1'b0, 1'b1, 10'd5, 10'd1, 4'd3, 4'd2, 32'ha00);
		configure_layer(1'b1, 1'b1, 10'd2, 10'd3, 4'd3, 4'd2, 32'hc00);
		release_and_run();
		stream_frames(1, 1'b0);
		repeat (50) begin
			@(negedge clk_ppu);
			check_flag("running_o", running_o, 1'b0);
			check_flag("pix_vld_o", pix_vld_o, 1'b0);
		end
		finish_test("halt at frame end");

		$display("Summary: %0d tests, %0d failed, %0d errors", test_num, fail_tests, err_total);
		if (fail_tests == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: tb_ppu_assertions.sv
/*
 * Memory bus protocol checks
 * Bound into the arbiter to check one transfer at a time with a stable address
 */
module ppu_bus_arbiter_assertions (
	input logic           clk_ppu,
	input logic           rst_n_ppu,
	input logic           mem_req_o,
	input ppu_pkg::addr_t mem_addr_o,
	input logic           mem_ack_i
);
	timeunit 1ns;
	timeprecision 100ps;
	import ppu_pkg::*;

	// Failed checks so far
	int fail_cnt = 0;

	// Address and request held until the ack
	a_addr_stable: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
		else begin
			$error("mem_addr_o changed or request dropped while waiting for ack");
			fail_cnt++;
		end

	a_ack_with_req: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		mem_ack_i |-> mem_req_o)
		else begin
			$error("mem_ack_i seen without an open request");
			fail_cnt++;
		end

	// Request closes right after its ack
	a_single_ack: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		mem_ack_i |=> !mem_req_o && !mem_ack_i)
		else begin
			$error("more than one ack for one request");
			fail_cnt++;
		end

endmodule

bind ppu_bus_arbiter ppu_bus_arbiter_assertions i_arb_checks (.*);

// File: ppu_top.sv
/*
 * PPU top level
 * Bitmap layers behind one bus arbiter, blended into a pixel stream
 */
module ppu_top #(
	parameter int N_BG = 2
) (
	input  logic                        clk_ppu,
	input  logic                        rst_n_ppu,
	input  ppu_pkg::ppu_cfg_t           cfg_i,
	input  ppu_pkg::bg_cfg_t [N_BG-1:0] bg_cfg_i,
	input  logic                        run_i,
	input  logic                        halt_i,
	output logic                        running_o,
	output logic                        mem_req_o,
	output ppu_pkg::addr_t              mem_addr_o,
	input  logic                        mem_ack_i,
	input  ppu_pkg::pixel_t             mem_rdata_i,
	output logic                        pix_vld_o,
	output ppu_pkg::colour_t            pix_o,
	input  logic                        pix_rdy_i
);
	import ppu_pkg::*;

	logic                advance;
	logic                end_of_frame;
	logic [N_BG-1:0]     layer_en;
	logic [N_BG-1:0]     fetch_vld;
	bus_req_t [N_BG-1:0] fetch_req;
	logic [N_BG-1:0]     fetch_ack;
	pixel_t              fetch_data;
	logic [N_BG-1:0]     px_vld;
	pixel_t [N_BG-1:0]   px;
	logic [N_BG-1:0]     px_pop;

	// ----------------------------------------
	// Raster and run control

	// Only the frame mark is used here
	ppu_raster_counter u_raster (
		.clk_ppu        (clk_ppu),
		.rst_n_ppu      (rst_n_ppu),
		.cfg_i          (cfg_i),
		.advance_i      (advance),
		.beam_x_o       (),
		.beam_y_o       (),
		.end_of_frame_o (end_of_frame)
	);

	ppu_run_ctrl u_run (
		.clk_ppu        (clk_ppu),
		.rst_n_ppu      (rst_n_ppu),
		.cfg_i          (cfg_i),
		.run_i          (run_i),
		.halt_i         (halt_i),
		.advance_i      (advance),
		.end_of_frame_i (end_of_frame),
		.running_o      (running_o)
	);

	// ----------------------------------------
	// Layers

	for (genvar i = 0; i < N_BG; i++) begin : g_bg
		assign layer_en[i] = bg_cfg_i[i].enable;

		ppu_background u_bg (
			.clk_ppu      (clk_ppu),
			.rst_n_ppu    (rst_n_ppu),
			.cfg_i        (bg_cfg_i[i]),
			.disp_cfg_i   (cfg_i),
			.fetch_vld_o  (fetch_vld[i]),
			.fetch_req_o  (fetch_req[i]),
			.fetch_ack_i  (fetch_ack[i]),
			.fetch_data_i (fetch_data),
			.px_vld_o     (px_vld[i]),
			.px_o         (px[i]),
			.px_pop_i     (px_pop[i])
		);
	end

	// ----------------------------------------
	// Bus and blend

	ppu_bus_arbiter #(
		.N_BG (N_BG)
	) u_arb (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.req_vld_i   (fetch_vld),
		.req_i       (fetch_req),
		.ack_o       (fetch_ack),
		.rdata_o     (fetch_data),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i)
	);

	ppu_blender #(
		.N_BG (N_BG)
	) u_blend (
		.cfg_i      (cfg_i),
		.layer_en_i (layer_en),
		.px_vld_i   (px_vld),
		.px_i       (px),
		.running_i  (running_o),
		.pix_rdy_i  (pix_rdy_i),
		.pix_vld_o  (pix_vld_o),
		.pix_o      (pix_o),
		.pop_o      (px_pop),
		.advance_o  (advance)
	);

endmodule

// File: ppu_run_ctrl.sv
/*
 * Run control
 * Run/halt FSM with optional stop at the end of a frame
 */
module ppu_run_ctrl (
	input  logic              clk_ppu,
	input  logic              rst_n_ppu,
	input  ppu_pkg::ppu_cfg_t cfg_i,
	input  logic              run_i,
	input  logic              halt_i,
	input  logic              advance_i,
	input  logic              end_of_frame_i,
	output logic              running_o
);
	import ppu_pkg::*;

	run_state_t state_q;
	run_state_t state_nxt;
	logic       running_q;

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			STOPPED:  if (run_i && !halt_i) state_nxt = RUNNING;
			RUNNING: begin
				if (halt_i) begin
					state_nxt = STOPPED;
				end else if (cfg_i.halt_vsync && advance_i && end_of_frame_i) begin
					// Last pixel of the frame just went out
					state_nxt = STOPPING;
				end
			end
			STOPPING: state_nxt = STOPPED;
			default:  state_nxt = STOPPED;
		endcase
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			state_q   <= STOPPED;
			running_q <= 1'b0;
		end else begin
			state_q   <= state_nxt;
			running_q <= (state_nxt == RUNNING);
		end
	end

	assign running_o = running_q;

endmodule

// File: ppu_blender.sv
/*
 * Layer blender
 * Highest enabled opaque layer wins, else the default colour
 */
module ppu_blender #(
	parameter int N_BG = 2
) (
	input  ppu_pkg::ppu_cfg_t          cfg_i,
	input  logic [N_BG-1:0]            layer_en_i,
	input  logic [N_BG-1:0]            px_vld_i,
	input  ppu_pkg::pixel_t [N_BG-1:0] px_i,
	input  logic                       running_i,
	input  logic                       pix_rdy_i,
	output logic                       pix_vld_o,
	output ppu_pkg::colour_t           pix_o,
	output logic [N_BG-1:0]            pop_o,
	output logic                       advance_o
);
	import ppu_pkg::*;

	logic handshake;

	// Disabled layers never hold up the stream
	assign pix_vld_o = running_i && (&(px_vld_i | ~layer_en_i));

	// Later layers overwrite earlier ones
	always_comb begin
		pix_o = cfg_i.default_colour;
		for (int i = 0; i < N_BG; i++) begin
			if (layer_en_i[i] && px_i[i][ALPHA_BIT]) begin
				pix_o = px_i[i][ALPHA_BIT-1:0];
			end
		end
	end

	assign handshake = pix_vld_o && pix_rdy_i;
	assign advance_o = handshake;
	assign pop_o     = {N_BG{handshake}} & layer_en_i;

endmodule

// File: ppu_bus_arbiter.sv
/*
 * Memory bus arbiter
 * Fixed priority, lowest layer wins; one transfer in flight
 */
module ppu_bus_arbiter #(
	parameter int N_BG = 2
) (
	input  logic                         clk_ppu,
	input  logic                         rst_n_ppu,
	input  logic [N_BG-1:0]              req_vld_i,
	input  ppu_pkg::bus_req_t [N_BG-1:0] req_i,
	output logic [N_BG-1:0]              ack_o,
	output ppu_pkg::pixel_t              rdata_o,
	output logic                         mem_req_o,
	output ppu_pkg::addr_t               mem_addr_o,
	input  logic                         mem_ack_i,
	input  ppu_pkg::pixel_t              mem_rdata_i
);
	import ppu_pkg::*;

	localparam int IDX_W = (N_BG > 1) ? $clog2(N_BG) : 1;

	arb_state_t       state_q;
	logic [IDX_W-1:0] win_idx;
	logic [IDX_W-1:0] sel_q;
	bus_req_t         req_q;

	// Lowest-numbered valid requester
	always_comb begin
		win_idx = '0;
		for (int i = N_BG - 1; i >= 0; i--) begin
			if (req_vld_i[i]) begin
				win_idx = IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			state_q <= ARB_IDLE;
			sel_q   <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (|req_vld_i) begin
						state_q <= ARB_BUSY;
						sel_q   <= win_idx;
					end
				end
				ARB_BUSY: begin
					if (mem_ack_i) begin
						state_q <= ARB_IDLE;
					end
				end
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	// Address held for the whole transfer
	always_ff @(posedge clk_ppu) begin
		if (state_q == ARB_IDLE && |req_vld_i) begin
			req_q <= req_i[win_idx];
		end
	end

	assign mem_req_o  = (state_q == ARB_BUSY);
	assign mem_addr_o = req_q.addr;

	// Ack goes back to the granted layer only
	always_comb begin
		ack_o = '0;
		if (mem_req_o && mem_ack_i) begin
			ack_o[sel_q] = 1'b1;
		end
	end

	assign rdata_o = mem_rdata_i;

endmodule

// File: ppu_background.sv
/*
 * Bitmap background layer
 * Fetches one pixel word per screen position from a scrolled,
 * wrapping playfield and queues the words for the blender
 */
module ppu_background (
	input  logic              clk_ppu,
	input  logic              rst_n_ppu,
	input  ppu_pkg::bg_cfg_t  cfg_i,
	input  ppu_pkg::ppu_cfg_t disp_cfg_i,
	output logic              fetch_vld_o,
	output ppu_pkg::bus_req_t fetch_req_o,
	input  logic              fetch_ack_i,
	input  ppu_pkg::pixel_t   fetch_data_i,
	output logic              px_vld_o,
	output ppu_pkg::pixel_t   px_o,
	input  logic              px_pop_i
);
	import ppu_pkg::*;

	// Fetch-ahead screen position, runs ahead of the raster
	coord_t     fx_q;
	coord_t     fy_q;
	pf_coord_t  mask_w;
	pf_coord_t  mask_h;
	pf_coord_t  pf_x;
	pf_coord_t  pf_y;
	addr_t      pix_idx;

	pixel_t     buf_q [2];
	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic [1:0] count_q;
	logic       push;
	logic       pop;

	// ----------------------------------------
	// Address generation

	assign mask_w = ~({$bits(pf_coord_t){1'b1}} << cfg_i.log_w);
	assign mask_h = ~({$bits(pf_coord_t){1'b1}} << cfg_i.log_h);

	// Scrolled position, modulo the playfield size
	assign pf_x = (pf_coord_t'(fx_q) + cfg_i.scroll_x) & mask_w;
	assign pf_y = (pf_coord_t'(fy_q) + cfg_i.scroll_y) & mask_h;

	assign pix_idx          = (addr_t'(pf_y) << cfg_i.log_w) + addr_t'(pf_x);
	assign fetch_req_o.addr = cfg_i.base + (pix_idx << 1);

	// A single fetch at a time, only while a slot is free
	assign fetch_vld_o = cfg_i.enable && (count_q != 2'd2);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			fx_q <= '0;
			fy_q <= '0;
		end else if (fetch_ack_i) begin
			if (fx_q == disp_cfg_i.disp_w) begin
				fx_q <= '0;
				if (fy_q == disp_cfg_i.disp_h) begin
					fy_q <= '0;
				end else begin
					fy_q <= fy_q + 1'b1;
				end
			end else begin
				fx_q <= fx_q + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Pixel buffer, two entries

	assign push = fetch_ack_i;
	assign pop  = px_pop_i && px_vld_o;

	always_ff @(posedge clk_ppu) begin
		if (push) begin
			buf_q[wr_ptr_q] <= fetch_data_i;
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr_q <= ~wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= ~rd_ptr_q;
			end
			count_q <= count_q + 2'(push) - 2'(pop);
		end
	end

	assign px_vld_o = cfg_i.enable && (count_q != 2'd0);
	assign px_o     = buf_q[rd_ptr_q];

endmodule

// File: ppu_raster_counter.sv
/*
 * Raster counter
 * Walks the beam over the display area, one step per output pixel
 */
module ppu_raster_counter (
	input  logic              clk_ppu,
	input  logic              rst_n_ppu,
	input  ppu_pkg::ppu_cfg_t cfg_i,
	input  logic              advance_i,
	output ppu_pkg::coord_t   beam_x_o,
	output ppu_pkg::coord_t   beam_y_o,
	output logic              end_of_frame_o
);
	import ppu_pkg::*;

	coord_t x_q;
	coord_t y_q;
	logic   end_of_row;

	assign end_of_row     = (x_q == cfg_i.disp_w);
	assign end_of_frame_o = end_of_row && (y_q == cfg_i.disp_h);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_q <= '0;
			y_q <= '0;
		end else if (advance_i) begin
			if (end_of_row) begin
				x_q <= '0;
				// Wrap to the top after the last row
				if (end_of_frame_o) begin
					y_q <= '0;
				end else begin
					y_q <= y_q + 1'b1;
				end
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	assign beam_x_o = x_q;
	assign beam_y_o = y_q;

endmodule

// File: ppu_pkg.sv
/*
 * PPU shared definitions
 * Width types, configuration and bus structs, FSM encodings
 */
package ppu_pkg;

	// ----------------------------------------
	// Widths with a meaning

	// Screen coordinate or display size
	typedef logic [8:0]  coord_t;
	// Playfield coordinate or scroll value
	typedef logic [9:0]  pf_coord_t;
	// log2 of a playfield dimension, 3..10
	typedef logic [3:0]  log_size_t;
	// RGB555
	typedef logic [14:0] colour_t;
	// Memory pixel word, alpha flag on top of a colour
	typedef logic [15:0] pixel_t;
	typedef logic [31:0] addr_t;

	localparam int ALPHA_BIT = 15;

	// ----------------------------------------
	// Configuration

	typedef struct packed {
		logic      enable;
		pf_coord_t scroll_x;
		pf_coord_t scroll_y;
		log_size_t log_w;
		log_size_t log_h;
		addr_t     base;
	} bg_cfg_t;

	// disp_w/disp_h hold the last valid x/y
	typedef struct packed {
		coord_t  disp_w;
		coord_t  disp_h;
		colour_t default_colour;
		logic    halt_vsync;
	} ppu_cfg_t;

	// Fetch request, room for a size field later
	typedef struct packed {
		addr_t addr;
	} bus_req_t;

	// ----------------------------------------
	// FSM encodings

	typedef enum logic [1:0] {STOPPED, RUNNING, STOPPING} run_state_t;

	typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

endpackage
